// ==== vseq_params.svh ====
// Sequencer sizing: instruction ID count, register file size and unit queue depths
`ifndef VSEQ_PARAMS_SVH
`define VSEQ_PARAMS_SVH

// Number of instruction IDs that can be in flight
`define VSEQ_NR_VINSN 8

// Architectural vector registers
`define VSEQ_NR_VREGS 32

// Max outstanding instructions per functional unit
`define VSEQ_ALU_DEPTH 4
`define VSEQ_MUL_DEPTH 2
`define VSEQ_LD_DEPTH  2
`define VSEQ_ST_DEPTH  2

`endif

// ==== vseq_isa_pkg.sv ====
// Architectural types of the vector ISA as seen by the dispatcher
`default_nettype none
`include "vseq_params.svh"

package vseq_isa_pkg;

  // Opcode, grouped by target unit
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VMUL  = 3'd4,
    VMACC = 3'd5,
    VLE   = 3'd6,
    VSE   = 3'd7
  } vop_e;

  // Vector register index
  typedef logic [$clog2(`VSEQ_NR_VREGS)-1:0] vreg_t;

  // Request fields coming from the dispatcher
  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  use_vd;
    logic  use_vs1;
    logic  use_vs2;
  } vreq_t;

endpackage

`default_nettype wire

// ==== vseq_uarch_pkg.sv ====
// Microarchitectural types of the sequencer: IDs, units and the issued request
`default_nettype none
`include "vseq_params.svh"

package vseq_uarch_pkg;

  import vseq_isa_pkg::*;

  // Instruction ID
  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;

  // One bit per ID
  // Used for hazard vectors and the running set
  typedef logic [`VSEQ_NR_VINSN-1:0] vid_vec_t;

  // Functional units, values double as counter index
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_LD  = 2'd2,
    UNIT_ST  = 2'd3
  } unit_e;

  // Request handed to the functional units
  typedef struct packed {
    vid_t     id;
    unit_e    unit;
    vop_e     op;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    vid_vec_t hazard;
  } issue_req_t;

endpackage

`default_nettype wire

// ==== vseq_ifs.sv ====
// Internal interfaces: unit admission and issue handshake
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////
// Admission between unit block and scoreboard
////////////////////////////////////////

interface vseq_admit_if;
  import vseq_uarch_pkg::*;

  // Unit decoded from the current opcode
  unit_e unit;
  // Decoded unit still has room
  logic  credit_ok;
  // Request taken this cycle, with its ID
  logic  accept;
  vid_t  accept_id;

  modport admit (output unit, output credit_ok, input accept, input accept_id);
  modport sched (input unit, input credit_ok, output accept, output accept_id);
endinterface

////////////////////////////////////////
// Issue from scoreboard into the output register
////////////////////////////////////////

interface vseq_issue_if;
  import vseq_uarch_pkg::*;

  logic       valid;
  logic       ready;
  issue_req_t req;

  modport src (output valid, output req, input ready);
  modport dst (input valid, input req, output ready);
endinterface

`default_nettype wire

// ==== vseq_unit_admit.sv ====
// Unit admission: opcode decode and per-unit outstanding instruction limits
`timescale 1ns/1ps
`default_nettype none
`include "vseq_params.svh"

module vseq_unit_admit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vseq_isa_pkg::vop_e   req_op_i,
  input  logic                 done_valid_i,
  input  vseq_uarch_pkg::vid_t done_id_i,
  vseq_admit_if.admit          adm
);
  import vseq_isa_pkg::*;
  import vseq_uarch_pkg::*;

  localparam int unsigned NrUnits = 4;
  // A unit never holds more than all IDs
  localparam int unsigned CntW = $clog2(`VSEQ_NR_VINSN + 1);
  // Indexed by unit_e value
  localparam int unsigned UnitDepth [NrUnits] = '{
    `VSEQ_ALU_DEPTH, `VSEQ_MUL_DEPTH, `VSEQ_LD_DEPTH, `VSEQ_ST_DEPTH
  };

  logic [NrUnits-1:0][CntW-1:0] cnt_q;
  logic [NrUnits-1:0]           cnt_up;
  logic [NrUnits-1:0]           cnt_dn;
  // Unit each live ID went to
  unit_e [`VSEQ_NR_VINSN-1:0]   rec_unit_q;
  vid_vec_t                     rec_vld_q;
  logic                         done_hit;

  function automatic unit_e decode_unit(vop_e op);
    unique case (op)
      VADD, VSUB, VAND, VOR: decode_unit = UNIT_ALU;
      VMUL, VMACC:           decode_unit = UNIT_MUL;
      VLE:                   decode_unit = UNIT_LD;
      default:               decode_unit = UNIT_ST;
    endcase
  endfunction

  assign adm.unit      = decode_unit(req_op_i);
  assign adm.credit_ok = cnt_q[adm.unit] < CntW'(UnitDepth[adm.unit]);

  // Stray dones for non-running IDs do not touch the counters
  assign done_hit = done_valid_i & rec_vld_q[done_id_i];

  always_comb begin
    for (int u = 0; u < NrUnits; u++) begin
      cnt_up[u] = adm.accept & (adm.unit == unit_e'(u));
      cnt_dn[u] = done_hit & (rec_unit_q[done_id_i] == unit_e'(u));
    end
  end

  ////////////////////////////////////////
  // Counters and per-ID record
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      rec_vld_q <= '0;
    end else begin
      // Up and down together cancel out
      for (int u = 0; u < NrUnits; u++) begin
        if (cnt_up[u] && !cnt_dn[u]) cnt_q[u] <= cnt_q[u] + 1'b1;
        if (cnt_dn[u] && !cnt_up[u]) cnt_q[u] <= cnt_q[u] - 1'b1;
      end
      // Done first, so a reused ID keeps its new record
      if (done_hit) rec_vld_q[done_id_i] <= 1'b0;
      if (adm.accept) rec_vld_q[adm.accept_id] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (adm.accept) rec_unit_q[adm.accept_id] <= adm.unit;
  end

endmodule

`default_nettype wire

// ==== vseq_scoreboard.sv ====
// Scoreboard: ID allocation, RAW/WAR/WAW hazard tracking and running set
`timescale 1ns/1ps
`default_nettype none
`include "vseq_params.svh"

module vseq_scoreboard (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  input  vseq_isa_pkg::vop_e                            req_op_i,
  input  vseq_isa_pkg::vreg_t                           req_vd_i,
  input  vseq_isa_pkg::vreg_t                           req_vs1_i,
  input  vseq_isa_pkg::vreg_t                           req_vs2_i,
  input  logic                                          req_use_vd_i,
  input  logic                                          req_use_vs1_i,
  input  logic                                          req_use_vs2_i,
  input  logic                                          done_valid_i,
  input  vseq_uarch_pkg::vid_t                          done_id_i,
  output vseq_uarch_pkg::vid_vec_t                      running_o,
  output vseq_uarch_pkg::vid_vec_t [`VSEQ_NR_VINSN-1:0] hazard_table_o,
  vseq_admit_if.sched                                   adm,
  vseq_issue_if.src                                     iss
);
  import vseq_isa_pkg::*;
  import vseq_uarch_pkg::*;

  // Last writer or reader of one register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_acc_t;

  vreq_t                              req;
  vid_vec_t                           running_q, running_d, running_live;
  vid_vec_t                           done_vec, haz_vec;
  vreg_acc_t [`VSEQ_NR_VREGS-1:0]     wr_list_q, wr_list_d, rd_list_q, rd_list_d;
  vid_vec_t [`VSEQ_NR_VINSN-1:0]      table_d;
  vid_t                               new_id;
  logic                               any_free;

  assign req = '{op: req_op_i, vd: req_vd_i, vs1: req_vs1_i, vs2: req_vs2_i,
                 use_vd: req_use_vd_i, use_vs1: req_use_vs1_i, use_vs2: req_use_vs2_i};

  // Retire first, so a done this cycle frees its ID and list entries
  always_comb begin
    done_vec = '0;
    if (done_valid_i) done_vec[done_id_i] = 1'b1;
  end
  assign running_live = running_q & ~done_vec;

  // Lowest free ID
  always_comb begin
    new_id   = '0;
    any_free = 1'b0;
    for (int i = `VSEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_live[i]) begin
        new_id   = vid_t'(i);
        any_free = 1'b1;
      end
    end
  end

  assign req_ready_o   = any_free & adm.credit_ok & iss.ready;
  assign adm.accept    = req_valid_i & req_ready_o;
  assign adm.accept_id = new_id;

  ////////////////////////////////////////
  // Hazards and list updates
  ////////////////////////////////////////

  always_comb begin
    haz_vec = '0;
    // Entries of finished IDs no longer count
    for (int r = 0; r < `VSEQ_NR_VREGS; r++) begin
      wr_list_d[r]       = wr_list_q[r];
      wr_list_d[r].valid = wr_list_q[r].valid & running_live[wr_list_q[r].vid];
      rd_list_d[r]       = rd_list_q[r];
      rd_list_d[r].valid = rd_list_q[r].valid & running_live[rd_list_q[r].vid];
    end
    // RAW on the sources
    if (req.use_vs1 && wr_list_d[req.vs1].valid) haz_vec[wr_list_d[req.vs1].vid] = 1'b1;
    if (req.use_vs2 && wr_list_d[req.vs2].valid) haz_vec[wr_list_d[req.vs2].vid] = 1'b1;
    // WAR and WAW on the destination
    if (req.use_vd) begin
      if (rd_list_d[req.vd].valid) haz_vec[rd_list_d[req.vd].vid] = 1'b1;
      if (wr_list_d[req.vd].valid) haz_vec[wr_list_d[req.vd].vid] = 1'b1;
    end
    running_d = running_live;
    table_d   = hazard_table_o;
    if (adm.accept) begin
      running_d[new_id] = 1'b1;
      table_d[new_id]   = haz_vec;
      if (req.use_vd)  wr_list_d[req.vd]  = '{vid: new_id, valid: 1'b1};
      if (req.use_vs1) rd_list_d[req.vs1] = '{vid: new_id, valid: 1'b1};
      if (req.use_vs2) rd_list_d[req.vs2] = '{vid: new_id, valid: 1'b1};
    end
    // Columns of IDs that are gone are dropped from every row
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) table_d[i] &= running_d;
  end

  assign iss.valid = adm.accept;
  assign iss.req   = '{id: new_id, unit: adm.unit, op: req.op, vd: req.vd,
                       vs1: req.vs1, vs2: req.vs2, hazard: haz_vec};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q      <= '0;
      wr_list_q      <= '0;
      rd_list_q      <= '0;
      hazard_table_o <= '0;
    end else begin
      running_q      <= running_d;
      wr_list_q      <= wr_list_d;
      rd_list_q      <= rd_list_d;
      hazard_table_o <= table_d;
    end
  end

  assign running_o = running_q;

endmodule

`default_nettype wire

// ==== vseq_issue_reg.sv ====
// Issue register: one-entry output stage holding the request under back-pressure
`timescale 1ns/1ps
`default_nettype none

module vseq_issue_reg (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  vseq_issue_if.dst                  iss,
  output logic                       issue_valid_o,
  input  logic                       issue_ready_i,
  output vseq_uarch_pkg::issue_req_t issue_req_o
);
  import vseq_uarch_pkg::*;

  logic       valid_q;
  issue_req_t req_q;

  // Room when empty or drained in this same cycle
  assign iss.ready = ~valid_q | issue_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (iss.valid && iss.ready) begin
      valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on an input transfer
  always_ff @(posedge clk_i) begin
    if (iss.valid && iss.ready) req_q <= iss.req;
  end

  assign issue_valid_o = valid_q;
  assign issue_req_o   = req_q;

endmodule

`default_nettype wire

// ==== vseq_top.sv ====
// Vector instruction sequencer top: admission, scoreboard and issue register
`timescale 1ns/1ps
`default_nettype none
`include "vseq_params.svh"

module vseq_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Dispatcher side
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  input  vseq_isa_pkg::vop_e                            req_op_i,
  input  vseq_isa_pkg::vreg_t                           req_vd_i,
  input  vseq_isa_pkg::vreg_t                           req_vs1_i,
  input  vseq_isa_pkg::vreg_t                           req_vs2_i,
  input  logic                                          req_use_vd_i,
  input  logic                                          req_use_vs1_i,
  input  logic                                          req_use_vs2_i,
  // Retirement from the units
  input  logic                                          done_valid_i,
  input  vseq_uarch_pkg::vid_t                          done_id_i,
  // Issue to the units
  output logic                                          issue_valid_o,
  input  logic                                          issue_ready_i,
  output vseq_uarch_pkg::vid_t                          issue_id_o,
  output vseq_uarch_pkg::unit_e                         issue_unit_o,
  output vseq_isa_pkg::vop_e                            issue_op_o,
  output vseq_isa_pkg::vreg_t                           issue_vd_o,
  output vseq_uarch_pkg::vid_vec_t                      issue_hazard_o,
  // Status
  output vseq_uarch_pkg::vid_vec_t                      running_o,
  output vseq_uarch_pkg::vid_vec_t [`VSEQ_NR_VINSN-1:0] hazard_table_o,
  output logic                                          idle_o
);
  import vseq_uarch_pkg::*;

  issue_req_t issue_req;

  vseq_admit_if admit_if ();
  vseq_issue_if issue_if ();

  vseq_unit_admit u_admit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_op_i     (req_op_i),
    .done_valid_i (done_valid_i),
    .done_id_i    (done_id_i),
    .adm          (admit_if.admit)
  );

  vseq_scoreboard u_sb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_op_i       (req_op_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .done_valid_i   (done_valid_i),
    .done_id_i      (done_id_i),
    .running_o      (running_o),
    .hazard_table_o (hazard_table_o),
    .adm            (admit_if.sched),
    .iss            (issue_if.src)
  );

  vseq_issue_reg u_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .iss           (issue_if.dst),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .issue_req_o   (issue_req)
  );

  // Fields the units need
  // Sources stay internal
  assign issue_id_o     = issue_req.id;
  assign issue_unit_o   = issue_req.unit;
  assign issue_op_o     = issue_req.op;
  assign issue_vd_o     = issue_req.vd;
  assign issue_hazard_o = issue_req.hazard;

  // Idle once nothing is running
  assign idle_o = ~|running_o;

endmodule

`default_nettype wire

// ==== vseq_assertions.sv ====
// Sequencer assertions: issue stability, legal dones and no grant with all IDs busy
`timescale 1ns/1ps
`default_nettype none

module vseq_assertions (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      req_ready_o,
  input logic                      done_valid_i,
  input vseq_uarch_pkg::vid_t      done_id_i,
  input vseq_uarch_pkg::vid_vec_t  running_o,
  input logic                      issue_valid_o,
  input logic                      issue_ready_i,
  input vseq_uarch_pkg::vid_t      issue_id_o,
  input vseq_uarch_pkg::unit_e     issue_unit_o,
  input vseq_isa_pkg::vop_e        issue_op_o,
  input vseq_isa_pkg::vreg_t       issue_vd_o,
  input vseq_uarch_pkg::vid_vec_t  issue_hazard_o
);

  // Stalled output keeps valid and payload
  issue_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ready_i |=> issue_valid_o && $stable(issue_id_o) &&
    $stable(issue_unit_o) && $stable(issue_op_o) && $stable(issue_vd_o) &&
    $stable(issue_hazard_o))
    else $error("issue outputs changed under back-pressure");

  // Units only retire what is running
  done_running_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_i |-> running_o[done_id_i])
    else $error("done for an ID that is not running");

  // A done in the same cycle frees an ID
  full_no_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&running_o) && !done_valid_i |-> !req_ready_o)
    else $error("request ready with every ID running");

endmodule

bind vseq_top vseq_assertions u_vseq_assertions (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_ready_o    (req_ready_o),
  .done_valid_i   (done_valid_i),
  .done_id_i      (done_id_i),
  .running_o      (running_o),
  .issue_valid_o  (issue_valid_o),
  .issue_ready_i  (issue_ready_i),
  .issue_id_o     (issue_id_o),
  .issue_unit_o   (issue_unit_o),
  .issue_op_o     (issue_op_o),
  .issue_vd_o     (issue_vd_o),
  .issue_hazard_o (issue_hazard_o)
);

`default_nettype wire

// ==== tb_vseq_top.sv ====
// Sequencer testbench with LFSR stimulus, a reference model of IDs and hazards and issue checks
`timescale 1ns/1ps
`default_nettype none
`include "vseq_params.svh"

module tb_vseq_top;
  import vseq_isa_pkg::*;
  import vseq_uarch_pkg::*;

  localparam int timeout_cycles = 200;
  localparam int rand_cycles    = 600;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_valid_i;
  logic                          req_ready_o;
  vop_e                          req_op_i;
  vreg_t                         req_vd_i;
  vreg_t                         req_vs1_i;
  vreg_t                         req_vs2_i;
  logic                          req_use_vd_i;
  logic                          req_use_vs1_i;
  logic                          req_use_vs2_i;
  logic                          done_valid_i;
  vid_t                          done_id_i;
  logic                          issue_valid_o;
  logic                          issue_ready_i;
  vid_t                          issue_id_o;
  unit_e                         issue_unit_o;
  vop_e                          issue_op_o;
  vreg_t                         issue_vd_o;
  vid_vec_t                      issue_hazard_o;
  vid_vec_t                      running_o;
  vid_vec_t [`VSEQ_NR_VINSN-1:0] hazard_table_o;
  logic                          idle_o;

  // Reference model state
  // Always one edge ahead of the next negedge check
  vid_vec_t                      m_running;
  vid_vec_t [`VSEQ_NR_VINSN-1:0] m_table;
  vid_t                          m_wr_id [`VSEQ_NR_VREGS];
  logic                          m_wr_vld [`VSEQ_NR_VREGS];
  vid_t                          m_rd_id [`VSEQ_NR_VREGS];
  logic                          m_rd_vld [`VSEQ_NR_VREGS];
  int                            m_cnt [4];
  unit_e                         m_unit [`VSEQ_NR_VINSN];
  logic                          m_issue_vld;
  issue_req_t                    exp_q [$];
  logic [31:0]                   lfsr_q;
  string                         test_name;

  vseq_top u_vseq_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_req(input string what, input issue_req_t want, input issue_req_t got);
    if (want !== got)
      abort_run($sformatf("error %s %s: expected %h actual %h", test_name, what, want, got));
  endtask

  task automatic check_vec(input string what, input vid_vec_t want, input vid_vec_t got);
    if (want !== got)
      abort_run($sformatf("error %s %s: expected %b actual %b", test_name, what, want, got));
  endtask

  task automatic check_bit(input string what, input logic want, input logic got);
    if (want !== got)
      abort_run($sformatf("error %s %s: expected %b actual %b", test_name, what, want, got));
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  // One step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic unit_e unit_of(input vop_e op);
    case (op)
      VMUL, VMACC: return UNIT_MUL;
      VLE:         return UNIT_LD;
      VSE:         return UNIT_ST;
      default:     return UNIT_ALU;
    endcase
  endfunction

  function automatic int depth_of(input unit_e u);
    case (u)
      UNIT_ALU: return `VSEQ_ALU_DEPTH;
      UNIT_MUL: return `VSEQ_MUL_DEPTH;
      UNIT_LD:  return `VSEQ_LD_DEPTH;
      default:  return `VSEQ_ST_DEPTH;
    endcase
  endfunction

  // Lowest clear bit
  // Returns -1 when none
  function automatic int free_id(input vid_vec_t busy);
    for (int i = 0; i < `VSEQ_NR_VINSN; i++)
      if (!busy[i]) return i;
    return -1;
  endfunction

  // Expected request for the current inputs
  // RAW on the sources and WAR and WAW on vd
  // Only live entries count
  function automatic issue_req_t expect_req(input vid_t id, input vid_vec_t live);
    issue_req_t r;
    r = '{id: id, unit: unit_of(req_op_i), op: req_op_i, vd: req_vd_i,
          vs1: req_vs1_i, vs2: req_vs2_i, hazard: '0};
    if (req_use_vs1_i && m_wr_vld[req_vs1_i] && live[m_wr_id[req_vs1_i]])
      r.hazard[m_wr_id[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && m_wr_vld[req_vs2_i] && live[m_wr_id[req_vs2_i]])
      r.hazard[m_wr_id[req_vs2_i]] = 1'b1;
    if (req_use_vd_i && m_rd_vld[req_vd_i] && live[m_rd_id[req_vd_i]])
      r.hazard[m_rd_id[req_vd_i]] = 1'b1;
    if (req_use_vd_i && m_wr_vld[req_vd_i] && live[m_wr_id[req_vd_i]])
      r.hazard[m_wr_id[req_vd_i]] = 1'b1;
    return r;
  endfunction

  // Sources are not on the top ports
  // The expected sources fill those fields
  function automatic issue_req_t observed_req(input vreg_t vs1, input vreg_t vs2);
    issue_req_t r;
    r = '{id: issue_id_o, unit: issue_unit_o, op: issue_op_o, vd: issue_vd_o,
          vs1: vs1, vs2: vs2, hazard: issue_hazard_o};
    return r;
  endfunction

  task automatic set_req(input vop_e op, input int vd, input int vs1, input int vs2,
                         input logic [2:0] use_f);
    req_op_i    = op;
    req_vd_i    = vreg_t'(vd);
    req_vs1_i   = vreg_t'(vs1);
    req_vs2_i   = vreg_t'(vs2);
    {req_use_vd_i, req_use_vs1_i, req_use_vs2_i} = use_f;
    req_valid_i = 1'b1;
  endtask

  // Holds the request until the edge that takes it
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      n++;
      if (n > timeout_cycles) abort_run("request was never accepted");
      else @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic send(input vop_e op, input int vd, input int vs1, input int vs2,
                      input logic [2:0] use_f);
    set_req(op, vd, vs1, vs2, use_f);
    wait_accept();
  endtask

  // Retires the lowest running ID each cycle
  task automatic retire_all();
    int n;
    n = 0;
    while (m_running != '0) begin
      if (n > timeout_cycles) abort_run("running IDs did not retire");
      else begin
        done_id_i    = vid_t'(free_id(~m_running));
        done_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        done_valid_i = 1'b0;
        n++;
      end
    end
  endtask

  ////////////////////////////////////////
  // Reference model at mid-cycle
  ////////////////////////////////////////

  always @(negedge clk_i) begin : model
    vid_vec_t   live;
    issue_req_t want;
    int         id;
    unit_e      u;
    logic       ready_exp;
    logic       acc;
    if (rst_ni) begin
      // State left by the last edge
      check_vec("running_o", m_running, running_o);
      for (int i = 0; i < `VSEQ_NR_VINSN; i++)
        check_vec("hazard_table_o row", m_table[i], hazard_table_o[i]);
      check_bit("idle_o", m_running == '0, idle_o);
      check_bit("issue_valid_o", m_issue_vld, issue_valid_o);
      // Done applies before allocation
      // Credit uses the old count
      live = m_running;
      if (done_valid_i) live[done_id_i] = 1'b0;
      id        = free_id(live);
      u         = unit_of(req_op_i);
      ready_exp = (id >= 0) && (m_cnt[u] < depth_of(u)) && (!m_issue_vld || issue_ready_i);
      check_bit("req_ready_o", ready_exp, req_ready_o);
      acc         = req_valid_i && ready_exp;
      m_issue_vld = acc || (m_issue_vld && !issue_ready_i);
      if (done_valid_i && m_running[done_id_i]) m_cnt[m_unit[done_id_i]]--;
      for (int r = 0; r < `VSEQ_NR_VREGS; r++) begin
        if (m_wr_vld[r] && !live[m_wr_id[r]]) m_wr_vld[r] = 1'b0;
        if (m_rd_vld[r] && !live[m_rd_id[r]]) m_rd_vld[r] = 1'b0;
      end
      if (acc) begin
        want = expect_req(vid_t'(id), live);
        exp_q.push_back(want);
        m_cnt[u]++;
        m_unit[id]  = u;
        live[id]    = 1'b1;
        m_table[id] = want.hazard;
        if (req_use_vd_i) begin
          m_wr_id[req_vd_i]  = vid_t'(id);
          m_wr_vld[req_vd_i] = 1'b1;
        end
        if (req_use_vs1_i) begin
          m_rd_id[req_vs1_i]  = vid_t'(id);
          m_rd_vld[req_vs1_i] = 1'b1;
        end
        if (req_use_vs2_i) begin
          m_rd_id[req_vs2_i]  = vid_t'(id);
          m_rd_vld[req_vs2_i] = 1'b1;
        end
      end
      // Finished IDs drop out of every row
      for (int i = 0; i < `VSEQ_NR_VINSN; i++) m_table[i] &= live;
      m_running = live;
    end
  end

  // Every issue transfer against the oldest predicted request
  always @(negedge clk_i) begin : compare
    if (rst_ni && issue_valid_o && issue_ready_i) begin
      if (exp_q.size() == 0) abort_run("issue transfer without an accepted request");
      else begin
        check_req("issue", exp_q[0], observed_req(exp_q[0].vs1, exp_q[0].vs2));
        void'(exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : main
    int         stall;
    int         start;
    logic       accepted;
    issue_req_t held;
    vop_e       ops [4];
    unit_e      units [4];
    ops           = '{VADD, VMUL, VLE, VSE};
    units         = '{UNIT_ALU, UNIT_MUL, UNIT_LD, UNIT_ST};
    lfsr_q        = 32'h6184;
    test_name     = "reset";
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_op_i      = VADD;
    req_vd_i      = '0;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    req_use_vd_i  = 1'b0;
    req_use_vs1_i = 1'b0;
    req_use_vs2_i = 1'b0;
    done_valid_i  = 1'b0;
    done_id_i     = '0;
    issue_ready_i = 1'b1;
    m_running     = '0;
    m_table       = '0;
    m_issue_vld   = 1'b0;
    for (int r = 0; r < `VSEQ_NR_VREGS; r++) begin
      m_wr_id[r]  = '0;
      m_wr_vld[r] = 1'b0;
      m_rd_id[r]  = '0;
      m_rd_vld[r] = 1'b0;
    end
    for (int u = 0; u < 4; u++) m_cnt[u] = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Idle right after reset
    @(negedge clk_i);
    check_bit("idle_o", 1'b1, idle_o);
    check_bit("issue_valid_o", 1'b0, issue_valid_o);
    check_bit("req_ready_o", 1'b1, req_ready_o);
    check_vec("running_o", '0, running_o);
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) check_vec("hazard row", '0, hazard_table_o[i]);
    @(posedge clk_i);
    #1;

    // Disjoint registers and one request per unit
    // IDs count up from 0
    test_name = "independent";
    for (int i = 0; i < 4; i++) begin
      send(ops[i], i + 1, i + 10, i + 20, 3'b111);
      held = '{id: vid_t'(i), unit: units[i], op: ops[i], vd: vreg_t'(i + 1),
               vs1: vreg_t'(i + 10), vs2: vreg_t'(i + 20), hazard: '0};
      check_req("issue one cycle after accept", held, observed_req(held.vs1, held.vs2));
    end
    retire_all();

    // Few registers so that hazards are common
    test_name = "random";
    stall     = 0;
    for (int c = 0; c < rand_cycles; c++) begin
      if (!req_valid_i && rand_bits(2) != 0) begin
        req_op_i    = vop_e'(rand_bits(3));
        req_vd_i    = vreg_t'(rand_bits(3));
        req_vs1_i   = vreg_t'(rand_bits(3));
        req_vs2_i   = vreg_t'(rand_bits(3));
        {req_use_vd_i, req_use_vs1_i, req_use_vs2_i} = 3'(rand_bits(3));
        req_valid_i = 1'b1;
      end
      done_valid_i = 1'b0;
      if (m_running != '0 && rand_bits(1) == 1) begin
        start = int'(rand_bits(3));
        // Lowest offset from start wins
        for (int k = `VSEQ_NR_VINSN - 1; k >= 0; k--)
          if (m_running[(start + k) % `VSEQ_NR_VINSN])
            done_id_i = vid_t'((start + k) % `VSEQ_NR_VINSN);
        done_valid_i = 1'b1;
      end
      issue_ready_i = rand_bits(2) != 0;
      @(negedge clk_i);
      accepted = req_valid_i && req_ready_o;
      if (!req_valid_i || accepted) stall = 0;
      else stall++;
      if (stall > timeout_cycles) abort_run("request stalled in the random phase");
      else begin
        @(posedge clk_i);
        #1;
        if (accepted) req_valid_i = 1'b0;
      end
    end
    req_valid_i   = 1'b0;
    done_valid_i  = 1'b0;
    issue_ready_i = 1'b1;
    retire_all();

    // MUL queue holds two
    test_name = "mul_limit";
    send(VMUL, 1, 2, 3, 3'b111);
    send(VMACC, 4, 5, 6, 3'b111);
    set_req(VMUL, 7, 8, 9, 3'b111);
    repeat (4) begin
      @(negedge clk_i);
      check_bit("req_ready_o", 1'b0, req_ready_o);
      @(posedge clk_i);
      #1;
    end
    // First MUL went to ID 0
    done_id_i    = '0;
    done_valid_i = 1'b1;
    @(posedge clk_i);
    #1;
    done_valid_i = 1'b0;
    wait_accept();
    retire_all();

    // Second request waits while the output is stalled
    test_name     = "backpressure";
    issue_ready_i = 1'b0;
    send(VADD, 1, 2, 3, 3'b111);
    // Every ID is free again so the request takes ID 0
    held = '{id: vid_t'(0), unit: UNIT_ALU, op: VADD, vd: vreg_t'(1),
             vs1: vreg_t'(2), vs2: vreg_t'(3), hazard: '0};
    check_req("issue one cycle after accept", held, observed_req(held.vs1, held.vs2));
    set_req(VSUB, 4, 1, 5, 3'b111);
    repeat (4) begin
      @(negedge clk_i);
      check_bit("req_ready_o", 1'b0, req_ready_o);
      check_req("held issue", held, observed_req(held.vs1, held.vs2));
      @(posedge clk_i);
      #1;
    end
    issue_ready_i = 1'b1;
    wait_accept();
    retire_all();

    // Four ALU, two MUL and two LD fill every ID
    // The store unit still has credit
    test_name = "fill";
    for (int i = 0; i < `VSEQ_NR_VINSN; i++)
      send(i < 4 ? VADD : (i < 6 ? VMUL : VLE), i % 3, (i + 1) % 3, (i + 2) % 3, 3'b111);
    set_req(VSE, 9, 10, 11, 3'b011);
    repeat (3) begin
      @(negedge clk_i);
      check_bit("req_ready_o", 1'b0, req_ready_o);
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
    retire_all();
    @(negedge clk_i);
    check_bit("idle_o", 1'b1, idle_o);
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) check_vec("hazard row", '0, hazard_table_o[i]);

    if (exp_q.size() != 0) abort_run("accepted requests never left the issue register");
    else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vseq_top.f ====
+incdir+.
vseq_isa_pkg.sv
vseq_uarch_pkg.sv
vseq_ifs.sv
vseq_unit_admit.sv
vseq_scoreboard.sv
vseq_issue_reg.sv
vseq_top.sv
vseq_assertions.sv
tb_vseq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vseq_top -f vseq_top.f -o tb_vseq_top
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_vseq_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
